//--- verilog/isaPkg.sv
package isaPkg;

        typedef logic [31:0] wordT;     // Data and address word
        typedef logic [4:0] regAddrT;   // Register index

        // Primary opcodes of the supported subset
        typedef enum logic [5:0] {
                opRtype = 6'h00,
                opJ     = 6'h02,
                opBeq   = 6'h04,
                opAddiu = 6'h09,
                opLw    = 6'h23,
                opSw    = 6'h2b
        } opcodeT;

        typedef enum logic [5:0] {
                fnAddu = 6'h21,
                fnSubu = 6'h23,
                fnAnd  = 6'h24,
                fnOr   = 6'h25,
                fnSlt  = 6'h2a
        } functT;

        // Instruction field positions
        localparam int opcodeLsb  = 26;
        localparam int rsLsb      = 21;
        localparam int rtLsb      = 16;
        localparam int rdLsb      = 11;
        localparam int functLsb   = 0;
        localparam int immWidth   = 16;     // I-type immediate
        localparam int indexWidth = 26;     // J-type target index

endpackage

//--- verilog/ctrlPkg.sv
package ctrlPkg;

        typedef enum logic [3:0] {
                stFetch,
                stFetchWait,
                stDecode,
                stExecR,
                stExecI,
                stWriteBack,
                stAddrCalc,
                stLoadWait,
                stLoadWrite,
                stStoreWait,
                stBranch,
                stJump
        } stateT;

        typedef enum logic [2:0] {
                aluAdd,
                aluSub,
                aluAnd,
                aluOr,
                aluSlt
        } aluOpT;

        typedef enum logic [1:0] {srcReg, srcImm, srcFour} aluSrcT;     // Second ALU operand

        typedef enum logic [1:0] {pcIncr, pcBranch, pcJump} pcSrcT;

endpackage

//--- verilog/ctrlBus.sv
`timescale 1ns/1ps

interface ctrlBus;
        import isaPkg::*;
        import ctrlPkg::*;

        logic irLoad;           // Capture fetched word
        logic pcLoad;
        logic regWrite;
        logic memToReg;         // Write back load data instead of ALU result
        logic regDst;           // Write to rd instead of rt
        logic addrFromAlu;      // Data access address from result register
        aluOpT aluOp;
        aluSrcT aluSrc;
        pcSrcT pcSrc;

        opcodeT opcode;
        functT funct;
        logic zero;

        modport ctl (
                output irLoad, pcLoad, regWrite, memToReg, regDst, addrFromAlu,
                output aluOp, aluSrc, pcSrc,
                input opcode, funct, zero
        );

        modport dp (
                input irLoad, pcLoad, regWrite, memToReg, regDst, addrFromAlu,
                input aluOp, aluSrc, pcSrc,
                output opcode, funct, zero
        );

endinterface

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
        input  ctrlPkg::aluOpT op,
        input  isaPkg::wordT a,
        input  isaPkg::wordT b,
        output isaPkg::wordT result,
        output logic zero
);
        import ctrlPkg::*;

        logic lessThan;

        assign lessThan = $signed(a) < $signed(b);      // Signed compare for SLT

        always_comb begin
                case (op)
                        aluAdd:  result = a + b;
                        aluSub:  result = a - b;
                        aluAnd:  result = a & b;
                        aluOr:   result = a | b;
                        aluSlt:  result = {31'd0, lessThan};
                        default: result = a + b;
                endcase
        end

        assign zero = (result == '0);

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
        input  logic Load,
        input  logic rstN,
        input  isaPkg::regAddrT readAddrA,
        input  isaPkg::regAddrT readAddrB,
        input  isaPkg::regAddrT writeAddr,
        input  logic writeEnable,
        input  isaPkg::wordT writeData,
        output isaPkg::wordT readDataA,
        output isaPkg::wordT readDataB
);
        import isaPkg::*;

        wordT regs [32];

        // Register zero is cleared on reset and never written
        always_ff @(posedge Load or negedge rstN) begin
                if (!rstN) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (writeEnable && (writeAddr != '0)) begin
                        regs[writeAddr] <= writeData;
                end
        end

        assign readDataA = regs[readAddrA];     // Combinational reads
        assign readDataB = regs[readAddrB];

endmodule

//--- verilog/control.sv
`timescale 1ns/1ps

module control (
        input  logic Load,
        input  logic rstN,
        input  logic memDone,
        output logic memEnable,
        output logic memWrite,
        ctrlBus.ctl bus
);
        import isaPkg::*;
        import ctrlPkg::*;

        stateT state;
        stateT stateNext;
        logic waitState;        // A memory request is open
        aluOpT functOp;         // ALU operation for R-type

        assign waitState = (state == stFetchWait) || (state == stLoadWait) ||
                           (state == stStoreWait);

        always_comb begin
                case (bus.funct)
                        fnAddu:  functOp = aluAdd;
                        fnSubu:  functOp = aluSub;
                        fnAnd:   functOp = aluAnd;
                        fnOr:    functOp = aluOr;
                        fnSlt:   functOp = aluSlt;
                        default: functOp = aluAdd;      // Unknown funct acts as ADDU
                endcase
        end

        // The request flops follow the state by one cycle, so a data access
        // raises memEnable only after the result register holds the address
        always_ff @(posedge Load or negedge rstN) begin
                if (!rstN) begin
                        state <= stFetch;
                        memEnable <= 1'b0;
                        memWrite <= 1'b0;
                end else begin
                        state <= stateNext;
                        memEnable <= (state == stFetch) || (waitState && !memDone);
                        memWrite <= (state == stStoreWait) && !memDone;
                end
        end

        always_comb begin
                stateNext = state;
                bus.irLoad = 1'b0;
                bus.pcLoad = 1'b0;
                bus.regWrite = 1'b0;
                bus.memToReg = 1'b0;
                bus.regDst = 1'b0;
                bus.addrFromAlu = 1'b0;
                bus.aluOp = aluAdd;
                bus.aluSrc = srcReg;
                bus.pcSrc = pcIncr;
                case (state)
                        stFetch: stateNext = stFetchWait;
                        stFetchWait: begin
                                if (memDone) begin
                                        bus.irLoad = 1'b1;
                                        stateNext = stDecode;
                                end
                        end
                        stDecode: begin
                                bus.aluSrc = srcFour;   // ALU forms PC + 4
                                bus.pcLoad = 1'b1;
                                case (bus.opcode)
                                        opRtype:    stateNext = stExecR;
                                        opAddiu:    stateNext = stExecI;
                                        opLw, opSw: stateNext = stAddrCalc;
                                        opBeq:      stateNext = stBranch;
                                        opJ:        stateNext = stJump;
                                        default:    stateNext = stFetch;    // Treated as NOP
                                endcase
                        end
                        stExecR: begin
                                bus.aluOp = functOp;
                                stateNext = stWriteBack;
                        end
                        stExecI: begin
                                bus.aluSrc = srcImm;
                                stateNext = stWriteBack;
                        end
                        stWriteBack: begin
                                bus.regWrite = 1'b1;
                                bus.regDst = (bus.opcode == opRtype);
                                stateNext = stFetch;
                        end
                        stAddrCalc: begin
                                bus.aluSrc = srcImm;
                                stateNext = (bus.opcode == opLw) ? stLoadWait : stStoreWait;
                        end
                        stLoadWait: begin
                                bus.addrFromAlu = 1'b1;
                                if (memDone) stateNext = stLoadWrite;
                        end
                        stLoadWrite: begin
                                bus.regWrite = 1'b1;
                                bus.memToReg = 1'b1;
                                stateNext = stFetch;
                        end
                        stStoreWait: begin
                                bus.addrFromAlu = 1'b1;
                                if (memDone) stateNext = stFetch;
                        end
                        stBranch: begin
                                bus.aluOp = aluSub;     // Zero flag compares rs and rt
                                bus.pcSrc = pcBranch;
                                bus.pcLoad = bus.zero;
                                stateNext = stFetch;
                        end
                        stJump: begin
                                bus.pcSrc = pcJump;
                                bus.pcLoad = 1'b1;
                                stateNext = stFetch;
                        end
                        default: stateNext = stFetch;
                endcase
        end

endmodule

//--- verilog/datapath.sv
`timescale 1ns/1ps

module datapath #(
        parameter isaPkg::wordT resetVector = 32'h0000_0000
) (
        input  logic Load,
        input  logic rstN,
        ctrlBus.dp bus,
        input  isaPkg::wordT memRdata,
        output isaPkg::wordT memAddr,
        output isaPkg::wordT memWdata
);
        import isaPkg::*;
        import ctrlPkg::*;

        wordT pc;
        wordT ir;
        wordT aluOut;           // Result register
        wordT loadData;         // Load data register
        wordT readDataA;
        wordT readDataB;
        wordT immExt;
        wordT opA;
        wordT opB;
        wordT aluY;
        wordT branchTarget;
        wordT jumpTarget;
        wordT nextPc;
        wordT writeData;
        regAddrT rsAddr;
        regAddrT rtAddr;
        regAddrT rdAddr;
        regAddrT writeAddr;

        assign bus.opcode = opcodeT'(ir[opcodeLsb +: $bits(opcodeT)]);
        assign bus.funct = functT'(ir[functLsb +: $bits(functT)]);
        assign rsAddr = ir[rsLsb +: $bits(regAddrT)];
        assign rtAddr = ir[rtLsb +: $bits(regAddrT)];
        assign rdAddr = ir[rdLsb +: $bits(regAddrT)];

        assign immExt = {{(32 - immWidth){ir[immWidth - 1]}}, ir[immWidth - 1:0]};
        assign branchTarget = pc + {immExt[29:0], 2'b00};   // PC already holds PC + 4
        assign jumpTarget = {pc[31:28], ir[indexWidth - 1:0], 2'b00};

        assign opA = (bus.aluSrc == srcFour) ? pc : readDataA;

        always_comb begin
                case (bus.aluSrc)
                        srcImm:  opB = immExt;
                        srcFour: opB = 32'd4;
                        default: opB = readDataB;
                endcase
        end

        always_comb begin
                case (bus.pcSrc)
                        pcBranch: nextPc = branchTarget;
                        pcJump:   nextPc = jumpTarget;
                        default:  nextPc = aluY;
                endcase
        end

        always_ff @(posedge Load or negedge rstN) begin
                if (!rstN) pc <= resetVector;
                else if (bus.pcLoad) pc <= nextPc;
        end

        always_ff @(posedge Load) begin
                if (bus.irLoad) ir <= memRdata;
                if (!bus.addrFromAlu) aluOut <= aluY;   // Held during a data access
                loadData <= memRdata;
        end

        assign writeAddr = bus.regDst ? rdAddr : rtAddr;
        assign writeData = bus.memToReg ? loadData : aluOut;
        assign memAddr = bus.addrFromAlu ? aluOut : pc;
        assign memWdata = readDataB;    // Store data is rt

        regFile uRegs (
                .Load(Load),
                .rstN(rstN),
                .readAddrA(rsAddr),
                .readAddrB(rtAddr),
                .writeAddr(writeAddr),
                .writeEnable(bus.regWrite),
                .writeData(writeData),
                .readDataA(readDataA),
                .readDataB(readDataB)
        );

        alu uAlu (
                .op(bus.aluOp),
                .a(opA),
                .b(opB),
                .result(aluY),
                .zero(bus.zero)
        );

endmodule

//--- verilog/cpuTop.sv
`timescale 1ns/1ps

module cpuTop #(
        parameter isaPkg::wordT resetVector = 32'h0000_0000
) (
        input  logic Load,
        input  logic rstN,
        input  logic memDone,
        input  isaPkg::wordT memRdata,
        output logic memEnable,
        output logic memWrite,
        output isaPkg::wordT memAddr,
        output isaPkg::wordT memWdata
);

        ctrlBus bus ();     // Strobes to datapath, decode status back

        control uCtrl (
                .Load(Load),
                .rstN(rstN),
                .memDone(memDone),
                .memEnable(memEnable),
                .memWrite(memWrite),
                .bus(bus.ctl)
        );

        datapath #(
                .resetVector(resetVector)
        ) uDp (
                .Load(Load),
                .rstN(rstN),
                .bus(bus.dp),
                .memRdata(memRdata),
                .memAddr(memAddr),
                .memWdata(memWdata)
        );

endmodule

//--- test/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
        import isaPkg::*;

        localparam wordT resetVec = 32'h0000_0400;
        localparam wordT dataBase = 32'h0000_2000;     // 32-word data window
        localparam wordT dumpBase = 32'h0000_3000;
        localparam int numRandom = 60;
        localparam int progLen = numRandom + 8;         // Random part, dump, halt
        localparam wordT haltAddr = resetVec + 32'(4 * (progLen - 1));
        localparam int maxCycles = progLen * 7 * 4 + 400;

        logic Load, rstN, memDone, memEnable, memWrite;
        wordT memRdata, memAddr, memWdata;
        integer seed = 32'h7ac2;
        int cycles = 0;
        wordT mem [wordT];              // Memory seen by the DUT
        wordT refMem [wordT];           // Reference model copy
        wordT refRegs [32];
        logic expWrite [$];
        wordT expAddr [$];
        wordT expData [$];
        logic pending, doneLast, halted, reqWrite;
        int waitLeft, haltFetches;
        wordT reqAddr, reqWdata;

        cpuTop #(.resetVector(resetVec)) uut (
                .Load(Load), .rstN(rstN), .memDone(memDone), .memRdata(memRdata),
                .memEnable(memEnable), .memWrite(memWrite), .memAddr(memAddr),
                .memWdata(memWdata)
        );

        always #2 Load = ~Load;

        function automatic int unsigned rnd(int unsigned n);
                return $unsigned($random(seed)) % n;
        endfunction

        // Unwritten words read back as a mix of the full address
        function automatic wordT fillWord(wordT a);
                return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
        endfunction

        function automatic regAddrT pickReg();
                return regAddrT'(1 + rnd(7));
        endfunction

        function automatic wordT rWord(functT fn, regAddrT rs, regAddrT rt, regAddrT rd);
                return {opRtype, rs, rt, rd, 5'd0, fn};
        endfunction

        function automatic wordT iWord(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
                return {op, rs, rt, imm};
        endfunction

        task automatic putWord(wordT a, wordT w);
                mem[a] = w;
                refMem[a] = w;
        endtask

        task automatic checkAddr(wordT got, wordT exp, string what);
                if (got !== exp) begin
                        $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
                        $display("** FAIL **");
                        $fatal(1);
                end
        endtask

        task automatic checkWord(wordT got, wordT exp, string what);
                if (got !== exp) begin
                        $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
                        $display("** FAIL **");
                        $fatal(1);
                end
        endtask

        task automatic checkFlag(logic got, logic exp, string what);
                if (got !== exp) begin
                        $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
                        $display("** FAIL **");
                        $fatal(1);
                end
        endtask

        task automatic genProgram();
                functT fnList [5] = '{fnAddu, fnSubu, fnAnd, fnOr, fnSlt};
                wordT addr;
                int kind;
                int skip;
                for (int i = 0; i < numRandom; i++) begin
                        addr = resetVec + 32'(4 * i);
                        kind = rnd(12);
                        skip = rnd(4);  // Forward distance for BEQ and J
                        if (i + 1 + skip > numRandom) skip = numRandom - i - 1;
                        if (kind < 5) putWord(addr, rWord(fnList[kind], pickReg(), pickReg(),
                                        pickReg()));
                        else if (kind == 7) putWord(addr, iWord(opLw, 5'd0, pickReg(),
                                        16'(dataBase + 32'(4 * rnd(32)))));
                        else if (kind == 8) putWord(addr, iWord(opSw, 5'd0, pickReg(),
                                        16'(dataBase + 32'(4 * rnd(32)))));
                        else if (kind == 9) putWord(addr, iWord(opBeq, pickReg(), pickReg(),
                                        16'(skip)));
                        else if (kind == 10) putWord(addr,
                                        {opJ, 26'((addr + 32'(4 + 4 * skip)) >> 2)});
                        else putWord(addr, iWord(opAddiu, pickReg(), pickReg(), 16'(rnd(65536))));
                end
                for (int k = 1; k < 8; k++) begin
                        putWord(resetVec + 32'(4 * (numRandom + k - 1)),
                                iWord(opSw, 5'd0, regAddrT'(k), 16'(dumpBase + 32'(4 * (k - 1)))));
                end
                putWord(haltAddr, {opJ, haltAddr[27:2]});       // Jump to itself
        endtask

        task automatic addEvent(logic w, wordT a, wordT d);
                expWrite.push_back(w);
                expAddr.push_back(a);
                expData.push_back(d);
        endtask

        task automatic runModel();
                wordT pc, instr, a, b, imm, addr, res;
                regAddrT rd;
                pc = resetVec;
                for (int step = 0; step < 4 * progLen; step++) begin
                        addEvent(1'b0, pc, '0);
                        if (pc == haltAddr) break;
                        instr = refMem[pc];
                        a = refRegs[instr[25:21]];
                        b = refRegs[instr[20:16]];
                        imm = {{16{instr[15]}}, instr[15:0]};
                        addr = a + imm;
                        rd = instr[20:16];
                        pc = pc + 4;
                        case (instr[31:26])
                                opRtype: begin
                                        rd = instr[15:11];
                                        case (instr[5:0])
                                                fnAddu:  res = a + b;
                                                fnSubu:  res = a - b;
                                                fnAnd:   res = a & b;
                                                fnOr:    res = a | b;
                                                default: res = ($signed(a) < $signed(b)) ?
                                                                32'd1 : 32'd0;
                                        endcase
                                end
                                opAddiu: res = addr;
                                opLw: begin
                                        addEvent(1'b0, addr, '0);
                                        res = refMem.exists(addr) ? refMem[addr] : fillWord(addr);
                                end
                                opSw: begin
                                        addEvent(1'b1, addr, b);
                                        refMem[addr] = b;
                                end
                                opBeq: if (a == b) pc = pc + {imm[29:0], 2'b00};
                                default: pc = {pc[31:28], instr[25:0], 2'b00};  // J
                        endcase
                        if (instr[31:26] inside {opRtype, opAddiu, opLw} && rd != 0)
                                refRegs[rd] = res;
                end
        endtask

        task automatic respond();
                pending = 1'b0;
                doneLast = 1'b1;
                memDone = 1'b1;
                if (reqWrite) mem[reqAddr] = reqWdata;
                else memRdata = mem.exists(reqAddr) ? mem[reqAddr] : fillWord(reqAddr);
        endtask

        task automatic expectRequest();
                logic w;
                wordT d;
                if (expAddr.size() == 0) begin
                        checkFlag(reqWrite, 1'b0, "memWrite after halt");
                        checkAddr(reqAddr, haltAddr, "fetch after halt");
                end else begin
                        w = expWrite.pop_front();
                        d = expData.pop_front();
                        checkFlag(reqWrite, w, "memWrite");
                        checkAddr(reqAddr, expAddr.pop_front(), "memAddr");
                        if (w) checkWord(reqWdata, d, "store data");
                end
                if (!reqWrite && reqAddr == haltAddr) haltFetches++;
                if (haltFetches >= 2 && expAddr.size() == 0) halted = 1'b1;
        endtask

        // Memory with 0 to 3 wait cycles per request
        always @(posedge Load) begin
                #1;
                if (!rstN) begin
                        checkFlag(memEnable, 1'b0, "memEnable in reset");
                        checkFlag(memWrite, 1'b0, "memWrite in reset");
                end else if (doneLast) begin
                        memDone = 1'b0;
                        doneLast = 1'b0;
                        checkFlag(memEnable, 1'b0, "memEnable after memDone");
                end else if (pending) begin
                        checkFlag(memEnable, 1'b1, "memEnable while waiting");
                        checkFlag(memWrite, reqWrite, "memWrite while waiting");
                        checkAddr(memAddr, reqAddr, "memAddr while waiting");
                        checkWord(memWdata, reqWdata, "memWdata while waiting");
                        if (waitLeft == 0) respond();
                        else waitLeft--;
                end else if (memEnable) begin
                        reqAddr = memAddr;
                        reqWrite = memWrite;
                        reqWdata = memWdata;
                        expectRequest();
                        pending = 1'b1;
                        waitLeft = rnd(4);
                        if (waitLeft == 0) respond();
                        else waitLeft--;
                end
        end

        always @(posedge Load) begin
                cycles++;
                if (cycles >= maxCycles) begin
                        $display("Timeout: halt loop not reached after %0d cycles", cycles);
                        $display("** FAIL **");
                        $fatal(1);
                end
        end

        initial begin
                Load = 1'b0;
                rstN = 1'b0;
                memDone = 1'b0;
                memRdata = '0;
                pending = 1'b0;
                doneLast = 1'b0;
                halted = 1'b0;
                haltFetches = 0;
                for (int i = 0; i < 32; i++) refRegs[i] = '0;
                genProgram();
                runModel();
                repeat (10) @(posedge Load);
                #1;
                rstN = 1'b1;
                wait (halted);  // Halt fetched twice with every expected event consumed
                $display("** PASS **");
                $finish;
        end

endmodule

//--- Makefile
TOP ?= cpuTb
FILES ?= files.f
VERILATOR ?= verilator
FLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILES)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '** PASS **' > /dev/null

clean:
	rm -rf obj_dir

//--- files.f
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/ctrlBus.sv
verilog/alu.sv
verilog/regFile.sv
verilog/control.sv
verilog/datapath.sv
verilog/cpuTop.sv
test/cpuTb.sv
